// ==== compile.f ====
+incdir+logic
+incdir+tests
logic/xdma_cfg_pkg.sv
logic/cfg_header_tracker.sv
logic/cfg_frame_splitter.sv
logic/cfg_write_issuer.sv
logic/xdma_cfg_sender_top.sv
tests/tb_xdma_cfg_sender.sv

// ==== Bender.yml ====
package:
  name: xdma_cfg_sender

sources:
  - include_dirs:
      - logic
    files:
      - logic/xdma_cfg_pkg.sv
      - logic/cfg_header_tracker.sv
      - logic/cfg_frame_splitter.sv
      - logic/cfg_write_issuer.sv
      - logic/xdma_cfg_sender_top.sv
  - target: test
    include_dirs:
      - logic
      - tests
    files:
      - tests/tb_xdma_cfg_sender.sv

// ==== tests/tb_cfg_model.svh ====
/*
  Reference model for the configuration sender testbench. Maps a remote
  address to its mailbox and queues the expected writes in send order.
*/
`ifndef TB_CFG_MODEL_SVH
`define TB_CFG_MODEL_SVH

// Writes still owed by the DUT, oldest first
cfg_write_t exp_q[$];

// Mailbox base below the end of the region holding the address
function automatic addr_t mailbox_addr(input addr_t remote);
  addr_t low_mask;
  addr_t region_top;
  low_mask = (addr_t'(1) << (`XDMA_ADDR_W - `XDMA_CHIP_ID_W)) - addr_t'(1);
  if ((remote & low_mask) >= `XDMA_MAIN_MEM_BASE) begin
    // Main memory end on the same chip
    region_top = (remote & ~low_mask) | `XDMA_MAIN_MEM_END;
  end else begin
    // Top of the enclosing cluster
    region_top = (remote / `XDMA_CLUSTER_SPACE + 1) * `XDMA_CLUSTER_SPACE;
  end
  return region_top - (`XDMA_CFG_IDX + 1) * `XDMA_MMIO_SLOT;
endfunction

// A zero length still carries the header frame
function automatic int unsigned frames_of(input frame_len_t flen);
  return (flen == 0) ? 1 : flen;
endfunction

// Four words per frame, lowest word first, 4 bytes apart
function automatic void queue_frame_beats(input wide_t frame, input addr_t base,
                                          input int unsigned frame_idx,
                                          input int unsigned n_frames);
  cfg_write_t  wr;
  int unsigned beat_idx;
  for (int k = 0; k < 4; k++) begin
    beat_idx = frame_idx * 4 + k;
    wr.addr  = base + 4 * beat_idx;
    wr.data  = frame[32*k +: 32];
    // Only the final word of the final frame
    wr.last  = (beat_idx == n_frames * 4 - 1);
    exp_q.push_back(wr);
  end
endfunction

`endif

// ==== tests/tb_xdma_cfg_sender.sv ====
/*
  Testbench for the configuration sender. Sends random header and body
  frames over the four-phase input, acks writes after random delays and
  checks every write against the reference model queue.
*/
`timescale 1ns/1ns
`default_nettype none
`include "xdma_cfg_defines.svh"

module tb_xdma_cfg_sender;
  import xdma_cfg_pkg::*;

  `include "tb_cfg_model.svh"

  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned RST_CYCLES = 8;
  localparam logic [31:0] SEED       = 32'd47212;
  localparam int unsigned LOW_W      = `XDMA_ADDR_W - `XDMA_CHIP_ID_W;
  // Worst case beats over all tests is 16 + 16 + 64 + 192 + 21
  localparam int unsigned MAX_BEATS  = 309;
  localparam int unsigned TIMEOUT    = 40 * MAX_BEATS + 200;

  logic       clk_i;
  logic       rst_ni;
  wide_t      cfg_frame_i;
  logic       cfg_req_i;
  logic       cfg_ack_o;
  cfg_write_t cfg_write_o;
  logic       wr_req_o;
  logic       wr_ack_i;

  logic [31:0] stim_seed;
  logic [31:0] sink_seed;
  int unsigned cycle_count  = 0;
  int unsigned error_count  = 0;
  int unsigned check_count  = 0;
  int unsigned test_count   = 0;
  int unsigned tests_failed = 0;
  int unsigned write_count  = 0;

  xdma_cfg_sender_top xdma_cfg_sender_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_frame_i (cfg_frame_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_write_o (cfg_write_o),
    .wr_req_o    (wr_req_o),
    .wr_ack_i    (wr_ack_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Watchdog
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("Timeout after %0d cycles, %0d writes never arrived", cycle_count, exp_q.size());
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Random numbers and checks
  // ----------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_seed = lcg_step(stim_seed);
    // Fold high bits down since low LCG bits repeat quickly
    return stim_seed ^ (stim_seed >> 15);
  endfunction

  // Random chip id with low bits inside main memory or a cluster
  function automatic addr_t random_addr(input logic in_main);
    logic [31:0] r;
    addr_t       low;
    r = stim_rand();
    if (in_main) begin
      low = `XDMA_MAIN_MEM_BASE + stim_rand() % (`XDMA_MAIN_MEM_END - `XDMA_MAIN_MEM_BASE);
    end else begin
      low = stim_rand() % `XDMA_MAIN_MEM_BASE;
    end
    return {r[`XDMA_ADDR_W-1:LOW_W], low[LOW_W-1:0]};
  endfunction

  task automatic check_value(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("[TEST] %s: ok", name);
    end else begin
      tests_failed++;
      $display("[TEST] %s: FAILED, %0d errors", name, error_count - errs_before);
    end
  endtask

  // ----------------------------------------
  // Four-phase input driver
  // ----------------------------------------
  task automatic send_frame(input wide_t frame);
    @(posedge clk_i);
    #1;
    cfg_frame_i = frame;
    cfg_req_i   = 1'b1;
    @(negedge clk_i);
    while (!cfg_ack_o) @(negedge clk_i);
    @(posedge clk_i);
    #1 cfg_req_i = 1'b0;
    @(negedge clk_i);
    while (cfg_ack_o) @(negedge clk_i);
  endtask

  // Random header of the given task type and length
  function automatic cfg_header_t make_header(input logic dma_type, input frame_len_t flen,
                                              input logic reader_main, input logic writer_main);
    cfg_header_t hdr;
    hdr.writer_addr  = random_addr(writer_main);
    hdr.reader_addr  = random_addr(reader_main);
    hdr.dma_id       = dma_id_t'(stim_rand());
    hdr.frame_length = flen;
    hdr.dma_type     = dma_type;
    hdr.payload      = 47'({stim_rand(), stim_rand()});
    return hdr;
  endfunction

  // Header plus body frames with expected writes queued before each send
  task automatic send_transfer(input logic dma_type, input frame_len_t flen,
                               input logic reader_main, input logic writer_main);
    cfg_header_t hdr;
    wide_t       body;
    addr_t       base;
    int unsigned n_frames;
    hdr      = make_header(dma_type, flen, reader_main, writer_main);
    base     = mailbox_addr(dma_type ? hdr.writer_addr : hdr.reader_addr);
    n_frames = frames_of(flen);
    queue_frame_beats(wide_t'(hdr), base, 0, n_frames);
    send_frame(wide_t'(hdr));
    for (int f = 1; f < n_frames; f++) begin
      body = {stim_rand(), stim_rand(), stim_rand(), stim_rand()};
      queue_frame_beats(body, base, f, n_frames);
      send_frame(body);
    end
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    while (exp_q.size() != 0 || wr_req_o || wr_ack_i) @(negedge clk_i);
  endtask

  // ----------------------------------------
  // Write sink and checker
  // ----------------------------------------
  initial begin : write_sink
    cfg_write_t  exp_wr;
    int unsigned delay;
    wr_ack_i  = 1'b0;
    sink_seed = SEED;
    forever begin
      @(negedge clk_i);
      if (wr_req_o) begin
        write_count++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Unexpected write at %0t ns while no write was pending", $time);
        end else begin
          exp_wr = exp_q.pop_front();
          check_value("cfg_write_o.addr", cfg_write_o.addr, exp_wr.addr);
          check_value("cfg_write_o.data", cfg_write_o.data, exp_wr.data);
          check_value("cfg_write_o.last", 32'(cfg_write_o.last), 32'(exp_wr.last));
        end
        // Random ack delay of 0 to 5 cycles
        sink_seed = lcg_step(sink_seed);
        delay = (sink_seed >> 16) % 6;
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        #1 wr_ack_i = 1'b1;
        @(negedge clk_i);
        while (wr_req_o) @(negedge clk_i);
        @(posedge clk_i);
        #1 wr_ack_i = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main_seq
    int unsigned errs;
    int unsigned writes_before;
    int unsigned beats_sent;
    frame_len_t  flen;
    cfg_header_t stale_hdr;
    rst_ni      = 1'b0;
    cfg_req_i   = 1'b0;
    cfg_frame_i = '0;
    stim_seed   = SEED;
    repeat (RST_CYCLES) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // Single-frame reads from cluster addresses
    errs = error_count;
    for (int i = 0; i < 4; i++) begin
      send_transfer(1'b0, 8'd1, 1'b0, stim_rand() % 2 == 1);
      wait_drain();
    end
    finish_test("read_cluster", errs);

    // Single-frame writes into main memory
    errs = error_count;
    for (int i = 0; i < 4; i++) begin
      send_transfer(1'b1, 8'd1, stim_rand() % 2 == 1, 1'b1);
      wait_drain();
    end
    finish_test("write_main_mem", errs);

    // Two to four frames per transfer
    errs = error_count;
    for (int i = 0; i < 4; i++) begin
      send_transfer(stim_rand() % 2 == 1, frame_len_t'(2 + stim_rand() % 3),
                    stim_rand() % 2 == 1, stim_rand() % 2 == 1);
      wait_drain();
    end
    finish_test("multi_frame", errs);

    // No gaps between transfers and only sink back-pressure
    errs          = error_count;
    writes_before = write_count;
    beats_sent    = 0;
    for (int i = 0; i < 12; i++) begin
      flen = frame_len_t'(1 + stim_rand() % 4);
      beats_sent += 4 * frames_of(flen);
      send_transfer(stim_rand() % 2 == 1, flen, stim_rand() % 2 == 1, stim_rand() % 2 == 1);
    end
    wait_drain();
    check_value("write count", write_count - writes_before, beats_sent);
    finish_test("back_to_back", errs);

    // Reset while a three-frame header holds ack and its opening write waits
    errs      = error_count;
    stale_hdr = make_header(1'b0, 8'd3, 1'b0, 1'b0);
    queue_frame_beats(wide_t'(stale_hdr), mailbox_addr(stale_hdr.reader_addr), 0, 3);
    // Only the opening write leaves before reset
    while (exp_q.size() > 1) exp_q.delete(exp_q.size() - 1);
    @(posedge clk_i);
    #1;
    cfg_frame_i = wide_t'(stale_hdr);
    cfg_req_i   = 1'b1;
    @(negedge clk_i);
    while (!wr_req_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    rst_ni    = 1'b0;
    cfg_req_i = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("cfg_ack_o", 32'(cfg_ack_o), 0);
    check_value("wr_req_o", 32'(wr_req_o), 0);
    // Fresh headers straight after a multi-frame transfer
    send_transfer(1'b0, 8'd3, 1'b0, 1'b1);
    send_transfer(1'b1, 8'd1, 1'b0, 1'b0);
    send_transfer(1'b0, 8'd0, 1'b1, 1'b0);
    wait_drain();
    finish_test("reset_and_new_header", errs);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, tests_failed, check_count, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/xdma_cfg_sender_top.sv ====
/*
  Sender-side configuration path of the inter-cluster DMA adapter.
  Chains header tracker, frame splitter and write issuer between two
  four-phase edges.
*/
`timescale 1ns/1ns
`default_nettype none

module xdma_cfg_sender_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  xdma_cfg_pkg::wide_t      cfg_frame_i,
  input  logic                     cfg_req_i,
  output logic                     cfg_ack_o,
  output xdma_cfg_pkg::cfg_write_t cfg_write_o,
  output logic                     wr_req_o,
  input  logic                     wr_ack_i
);
  import xdma_cfg_pkg::*;

  // ----------------------------------------
  // Stage links
  // ----------------------------------------
  cfg_frame_tok_t frame_tok;
  logic           frame_valid;
  logic           frame_ready;
  cfg_beat_tok_t  beat_tok;
  logic           beat_valid;
  logic           beat_ready;

  // Frames in, descriptor attached
  cfg_header_tracker cfg_header_tracker_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_frame_i   (cfg_frame_i),
    .cfg_req_i     (cfg_req_i),
    .cfg_ack_o     (cfg_ack_o),
    .frame_tok_o   (frame_tok),
    .frame_valid_o (frame_valid),
    .frame_ready_i (frame_ready)
  );

  // Wide to narrow
  cfg_frame_splitter cfg_frame_splitter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .frame_tok_i   (frame_tok),
    .frame_valid_i (frame_valid),
    .frame_ready_o (frame_ready),
    .beat_tok_o    (beat_tok),
    .beat_valid_o  (beat_valid),
    .beat_ready_i  (beat_ready)
  );

  // Addressed writes out
  cfg_write_issuer cfg_write_issuer_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .beat_tok_i   (beat_tok),
    .beat_valid_i (beat_valid),
    .beat_ready_o (beat_ready),
    .cfg_write_o  (cfg_write_o),
    .wr_req_o     (wr_req_o),
    .wr_ack_i     (wr_ack_i)
  );

endmodule

`default_nettype wire

// ==== logic/cfg_write_issuer.sv ====
/*
  Last stage of the configuration sender. Turns each beat into an addressed
  write into the remote mailbox, marks the final beat of the transfer and
  hands it out over a four-phase req/ack edge.
*/
`timescale 1ns/1ns
`default_nettype none
`include "xdma_cfg_defines.svh"

module cfg_write_issuer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  xdma_cfg_pkg::cfg_beat_tok_t beat_tok_i,
  input  logic                        beat_valid_i,
  output logic                        beat_ready_o,
  output xdma_cfg_pkg::cfg_write_t    cfg_write_o,
  output logic                        wr_req_o,
  input  logic                        wr_ack_i
);
  import xdma_cfg_pkg::*;

  // Byte shift for one narrow beat
  localparam int unsigned ByteShift = $clog2(`XDMA_NARROW_W / 8);

  beat_len_t beat_cnt_q;
  beat_len_t beat_idx;
  addr_t     beat_addr;
  logic      beat_last;
  logic      accept;

  // ----------------------------------------
  // Beat addressing
  // ----------------------------------------
  // Restart the count on a transfer's opening beat
  assign beat_idx = beat_tok_i.desc.first ? '0 : beat_cnt_q;

  assign beat_addr = beat_tok_i.desc.remote_addr + (addr_t'(beat_idx) << ByteShift);

  // Final beat of the whole transfer
  assign beat_last = (beat_idx == beat_tok_i.desc.beat_count - 1'b1);

  // ----------------------------------------
  // Four-phase output
  // ----------------------------------------
  // Idle only once both req and ack are low
  assign beat_ready_o = !wr_req_o && !wr_ack_i;
  assign accept = beat_valid_i && beat_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_req_o <= 1'b0;
    end else if (accept) begin
      wr_req_o <= 1'b1;
    end else if (wr_req_o && wr_ack_i) begin
      // Sink took the write
      wr_req_o <= 1'b0;
    end
  end

  // Beat position inside the current transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (accept) begin
      beat_cnt_q <= beat_idx + 1'b1;
    end
  end

  // Write stays put until the next accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cfg_write_o.addr <= beat_addr;
      cfg_write_o.data <= beat_tok_i.beat;
      cfg_write_o.last <= beat_last;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cfg_frame_splitter.sv ====
/*
  Second stage of the configuration sender. Loads one wide frame token and
  shifts it out as four narrow beats, least significant first, each tagged
  with the frame descriptor and a frame_last flag.
*/
`timescale 1ns/1ns
`default_nettype none
`include "xdma_cfg_defines.svh"

module cfg_frame_splitter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  xdma_cfg_pkg::cfg_frame_tok_t frame_tok_i,
  input  logic                         frame_valid_i,
  output logic                         frame_ready_o,
  output xdma_cfg_pkg::cfg_beat_tok_t  beat_tok_o,
  output logic                         beat_valid_o,
  input  logic                         beat_ready_i
);
  import xdma_cfg_pkg::*;

  wide_t                      shift_q;
  cfg_desc_t                  desc_q;
  logic [`XDMA_SPLIT_BITS-1:0] idx_q;
  logic                       busy_q;
  logic                       last_beat;
  logic                       beat_fire;
  logic                       load;

  // ----------------------------------------
  // Beat view of the held frame
  // ----------------------------------------
  assign last_beat = (idx_q == '1);
  assign beat_fire = busy_q && beat_ready_i;

  always_comb begin
    beat_tok_o.beat       = shift_q[`XDMA_NARROW_W-1:0];
    beat_tok_o.desc       = desc_q;
    // Only the opening beat of a header frame starts a transfer
    beat_tok_o.desc.first = desc_q.first && (idx_q == '0);
    beat_tok_o.frame_last = last_beat;
  end

  assign beat_valid_o = busy_q;

  // Free, or the final beat leaves this cycle
  assign frame_ready_o = !busy_q || (beat_fire && last_beat);
  assign load = frame_valid_i && frame_ready_o;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (load) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (beat_fire) begin
      busy_q <= !last_beat;
      idx_q  <= idx_q + 1'b1;
    end
  end

  // Frame payload, shifted down one beat per transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= frame_tok_i.frame;
      desc_q  <= frame_tok_i.desc;
    end else if (beat_fire) begin
      shift_q <= shift_q >> `XDMA_NARROW_W;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cfg_header_tracker.sv ====
/*
  First stage of the configuration sender. Takes wide frames over a four-phase
  req/ack edge, decodes header frames into a mailbox descriptor and tags the
  body frames with it. Offers each frame as a valid/ready token.
*/
`timescale 1ns/1ns
`default_nettype none
`include "xdma_cfg_defines.svh"

module cfg_header_tracker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  xdma_cfg_pkg::wide_t          cfg_frame_i,
  input  logic                         cfg_req_i,
  output logic                         cfg_ack_o,
  output xdma_cfg_pkg::cfg_frame_tok_t frame_tok_o,
  output logic                         frame_valid_o,
  input  logic                         frame_ready_i
);
  import xdma_cfg_pkg::*;

  // ----------------------------------------
  // Memory map constants
  // ----------------------------------------
  localparam int unsigned LowW = `XDMA_ADDR_W - `XDMA_CHIP_ID_W;
  localparam logic [LowW-1:0] MainBase = LowW'(`XDMA_MAIN_MEM_BASE);
  localparam logic [LowW-1:0] MainEnd = LowW'(`XDMA_MAIN_MEM_END);
  localparam addr_t ClusterSpace = addr_t'(`XDMA_CLUSTER_SPACE);
  // Clears the offset inside one cluster
  localparam addr_t ClusterMask = ~(ClusterSpace - addr_t'(1));
  localparam addr_t CfgOffset = addr_t'((`XDMA_CFG_IDX + 1) * `XDMA_MMIO_SLOT);

  // End of the region an address falls in
  function automatic addr_t region_end(addr_t addr);
    addr_t end_addr;
    if (addr[LowW-1:0] >= MainBase) begin
      // Main memory of the same chip
      end_addr = {addr[`XDMA_ADDR_W-1:LowW], MainEnd};
    end else begin
      end_addr = (addr & ClusterMask) + ClusterSpace;
    end
    return end_addr;
  endfunction

  cfg_header_t hdr;
  addr_t       remote_sel;
  frame_len_t  flen_eff;
  cfg_desc_t   hdr_desc;
  cfg_desc_t   body_desc_q;
  cfg_desc_t   tok_desc;
  hdr_state_e  state_q;
  hdr_state_e  state_d;
  frame_len_t  frame_cnt_q;
  frame_len_t  frame_total_q;
  logic        out_free;
  logic        capture;
  logic        body_done;

  // ----------------------------------------
  // Header decode
  // ----------------------------------------
  assign hdr = cfg_header_t'(cfg_frame_i);

  // Read task targets the reader, write task the writer
  assign remote_sel = hdr.dma_type ? hdr.writer_addr : hdr.reader_addr;

  // Zero length still carries the header itself
  assign flen_eff = (hdr.frame_length == '0) ? frame_len_t'(1) : hdr.frame_length;

  always_comb begin
    hdr_desc.remote_addr = region_end(remote_sel) - CfgOffset;
    hdr_desc.dma_id      = hdr.dma_id;
    hdr_desc.beat_count  = beat_len_t'(flen_eff) << `XDMA_SPLIT_BITS;
    hdr_desc.first       = 1'b1;
  end

  // Body frames reuse the held descriptor
  assign tok_desc = (state_q == HDR_BODY) ? body_desc_q : hdr_desc;

  // ----------------------------------------
  // Handshakes
  // ----------------------------------------
  // Output register empty or draining this cycle
  assign out_free = !frame_valid_o || frame_ready_i;
  // One capture per req pulse
  assign capture = cfg_req_i && !cfg_ack_o && out_free;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_ack_o     <= 1'b0;
      frame_valid_o <= 1'b0;
    end else begin
      if (capture) begin
        cfg_ack_o <= 1'b1;
      end else if (cfg_ack_o && !cfg_req_i) begin
        // Source released req
        cfg_ack_o <= 1'b0;
      end
      if (capture) begin
        frame_valid_o <= 1'b1;
      end else if (frame_ready_i) begin
        frame_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      frame_tok_o.frame <= cfg_frame_i;
      frame_tok_o.desc  <= tok_desc;
    end
  end

  // ----------------------------------------
  // Header/body FSM
  // ----------------------------------------
  assign body_done = (frame_cnt_q + 1'b1) == frame_total_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      HDR_IDLE: begin
        if (capture && hdr.frame_length > frame_len_t'(1)) begin
          state_d = HDR_BODY;
        end
      end
      HDR_BODY: begin
        if (capture && body_done) begin
          state_d = HDR_IDLE;
        end
      end
      default: state_d = HDR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= HDR_IDLE;
      frame_cnt_q   <= '0;
      frame_total_q <= '0;
    end else begin
      state_q <= state_d;
      if (capture && state_q == HDR_IDLE && state_d == HDR_BODY) begin
        // Header counts as the first frame
        frame_cnt_q   <= frame_len_t'(1);
        frame_total_q <= hdr.frame_length;
      end else if (capture && state_q == HDR_BODY) begin
        frame_cnt_q <= body_done ? '0 : frame_cnt_q + 1'b1;
      end
    end
  end

  // Descriptor kept for the body frames
  always_ff @(posedge clk_i) begin
    if (capture && state_q == HDR_IDLE) begin
      body_desc_q       <= hdr_desc;
      body_desc_q.first <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/xdma_cfg_pkg.sv ====
/*
  Shared types of the configuration sender: vector widths, header view,
  transfer descriptor, stage tokens, outgoing write and the header FSM states.
*/
`default_nettype none
`include "xdma_cfg_defines.svh"

package xdma_cfg_pkg;

  // ----------------------------------------
  // Plain vectors
  // ----------------------------------------
  typedef logic [`XDMA_ADDR_W-1:0]   addr_t;
  typedef logic [`XDMA_WIDE_W-1:0]   wide_t;
  typedef logic [`XDMA_NARROW_W-1:0] narrow_t;
  typedef logic [`XDMA_ID_W-1:0]     dma_id_t;
  typedef logic [`XDMA_FLEN_W-1:0]   frame_len_t;
  typedef logic [`XDMA_BLEN_W-1:0]   beat_len_t;

  // Header frame, MSB first, 128 bits in total
  typedef struct packed {
    addr_t        writer_addr;
    addr_t        reader_addr;
    dma_id_t      dma_id;
    frame_len_t   frame_length;
    // 0 read, 1 write
    logic         dma_type;
    logic [46:0]  payload;
  } cfg_header_t;

  // Per-transfer descriptor
  typedef struct packed {
    addr_t      remote_addr;
    dma_id_t    dma_id;
    beat_len_t  beat_count;
    // High only on the header frame
    logic       first;
  } cfg_desc_t;

  // Tracker to splitter
  typedef struct packed {
    wide_t      frame;
    cfg_desc_t  desc;
  } cfg_frame_tok_t;

  // Splitter to issuer
  typedef struct packed {
    narrow_t    beat;
    cfg_desc_t  desc;
    logic       frame_last;
  } cfg_beat_tok_t;

  // Outgoing addressed write
  typedef struct packed {
    addr_t      addr;
    narrow_t    data;
    logic       last;
  } cfg_write_t;

  typedef enum logic {
    HDR_IDLE = 1'b0,
    HDR_BODY = 1'b1
  } hdr_state_e;

endpackage

`default_nettype wire

// ==== logic/xdma_cfg_defines.svh ====
/*
  Width, memory map and mailbox macros for the configuration sender.
  Included by the package and by every RTL file that needs a constant.
*/
`ifndef XDMA_CFG_DEFINES_SVH
`define XDMA_CFG_DEFINES_SVH

// ----------------------------------------
// Data path widths
// ----------------------------------------
`define XDMA_ADDR_W        32
// Chip id sits in the top address bits
`define XDMA_CHIP_ID_W     4
`define XDMA_WIDE_W        128
`define XDMA_NARROW_W      32
// Four narrow beats per wide frame
`define XDMA_SPLIT_BITS    2
`define XDMA_ID_W          8
`define XDMA_FLEN_W        8
`define XDMA_BLEN_W        10

// ----------------------------------------
// Memory map
// ----------------------------------------
`define XDMA_CLUSTER_SPACE 'h0010_0000
// Main memory bounds in the bits below the chip id
`define XDMA_MAIN_MEM_BASE 'h0800_0000
`define XDMA_MAIN_MEM_END  'h0C00_0000

// Mailbox slots counted down from the region end
`define XDMA_MMIO_SLOT     (4 * 1024)
// Config slot index, mailbox is 8 KB below the end
`define XDMA_CFG_IDX       1

`endif
